// ==== rtl/overlay_pkg.sv ====
package overlay_pkg;

    // panel geometry, pixels and lines
    localparam int h_active    = 160;
    localparam int h_total     = 200;
    localparam int hsync_start = 164;
    localparam int hsync_end   = 180;
    localparam int v_active    = 120;
    localparam int v_total     = 130;
    localparam int vsync_start = 122;
    localparam int vsync_end   = 124;

    localparam int coord_w    = 8;
    localparam int value_w    = 12;   // processor word shown on screen
    localparam int glyph_size = 8;
    localparam int num_glyphs = 8;
    localparam int rgb_w      = 12;

    // digit strip, 15 slots of glyph_size pixels
    localparam int digits_x = 20;
    localparam int digits_y = 48;
    localparam int digits_w = 120;
    localparam int digits_h = 8;

    localparam int box_x = 16;
    localparam int box_y = 44;
    localparam int box_w = 128;
    localparam int box_h = 16;

    localparam int status_x = 76;
    localparam int status_y = 80;

    localparam logic [rgb_w-1:0] bg_color       = 12'h113;
    localparam logic [rgb_w-1:0] box_bg_color   = 12'h446;
    localparam logic [rgb_w-1:0] ink_color      = 12'hFFF;
    localparam logic [rgb_w-1:0] glyph_bg_color = 12'h224;

    // glyph numbers, one rom each
    localparam int glyph_zero        = 0;
    localparam int glyph_one         = 1;
    localparam int glyph_normal      = 2;
    localparam int glyph_uart        = 3;
    localparam int glyph_pause       = 4;
    localparam int glyph_fallthrough = 5;
    localparam int glyph_keypad      = 6;
    localparam int glyph_switch      = 7;

    // issue codes from the hazard unit, 5..7 are invalid
    typedef enum logic [2:0] {
        issue_none        = 3'd0,
        issue_uart        = 3'd1,
        issue_pause       = 3'd2,
        issue_fallthrough = 3'd3,
        issue_keypad      = 3'd4
    } issue_t;

    typedef logic [coord_w-1:0] coord_t;

    // bit 7 of each row is the leftmost pixel
    localparam logic [7:0] glyph_bitmap [0:num_glyphs-1][0:glyph_size-1] = '{
        '{8'h3C, 8'h66, 8'h6E, 8'h76, 8'h66, 8'h66, 8'h3C, 8'h00},   // "0"
        '{8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7E, 8'h00},   // "1"
        '{8'h00, 8'h01, 8'h03, 8'h06, 8'h8C, 8'hD8, 8'h70, 8'h20},   // normal, tick
        '{8'h24, 8'h42, 8'hFF, 8'h00, 8'h00, 8'hFF, 8'h42, 8'h24},   // uart, two-way arrows
        '{8'h00, 8'h66, 8'h66, 8'h66, 8'h66, 8'h66, 8'h66, 8'h00},   // pause bars
        '{8'h18, 8'h18, 8'h18, 8'h18, 8'h7E, 8'h3C, 8'h18, 8'h00},   // fallthrough, down arrow
        '{8'hDB, 8'hDB, 8'h00, 8'hDB, 8'hDB, 8'h00, 8'hDB, 8'hDB},   // keypad grid
        '{8'h00, 8'h7E, 8'h81, 8'hF9, 8'hF9, 8'h81, 8'h7E, 8'h00}    // switch toggle
    };

    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   display_en;
    } raster_t;

    // per-pixel decode, one cycle behind the raster
    typedef struct packed {
        logic       display_en;
        logic       in_status;
        logic       in_box;
        logic       in_digit;
        logic [2:0] glyph_row;
        logic [2:0] glyph_col;
        logic [3:0] digit_idx;   // digit number with blank slots removed
    } pixel_map_t;

endpackage

// ==== rtl/vga_timing.sv ====
`timescale 1ns/100ps

module vga_timing (
    input  logic                 clk,
    input  logic                 rst_n,
    output overlay_pkg::raster_t raster,
    output logic                 hsync,
    output logic                 vsync
);

    overlay_pkg::coord_t h_cnt;
    overlay_pkg::coord_t v_cnt;
    logic                hs_now;
    logic                vs_now;
    logic [2:0]          hs_pipe;   // registered sync plus two alignment stages
    logic [2:0]          vs_pipe;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == overlay_pkg::coord_t'(overlay_pkg::h_total - 1)) begin
            h_cnt <= '0;
            if (v_cnt == overlay_pkg::coord_t'(overlay_pkg::v_total - 1))
                v_cnt <= '0;
            else
                v_cnt <= v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            raster <= '0;
        end else begin
            raster.x          <= h_cnt;
            raster.y          <= v_cnt;
            raster.display_en <= (h_cnt < overlay_pkg::h_active) &&
                                 (v_cnt < overlay_pkg::v_active);
        end
    end

    // syncs are active low and follow the raster by the rgb pipeline depth
    assign hs_now = !((raster.x >= overlay_pkg::hsync_start) &&
                      (raster.x < overlay_pkg::hsync_end));
    assign vs_now = !((raster.y >= overlay_pkg::vsync_start) &&
                      (raster.y < overlay_pkg::vsync_end));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_pipe <= 3'b111;
            vs_pipe <= 3'b111;
        end else begin
            hs_pipe <= {hs_pipe[1:0], hs_now};
            vs_pipe <= {vs_pipe[1:0], vs_now};
        end
    end

    assign hsync = hs_pipe[2];
    assign vsync = vs_pipe[2];

    a_h_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
        h_cnt < overlay_pkg::h_total);

endmodule

// ==== rtl/coord_mapper.sv ====
`timescale 1ns/100ps

module coord_mapper (
    input  logic                    clk,
    input  logic                    rst_n,
    input  overlay_pkg::raster_t    raster,
    output overlay_pkg::pixel_map_t pmap
);

    overlay_pkg::coord_t dx_digits;
    overlay_pkg::coord_t dy_digits;
    logic [3:0]          slot;        // 8-pixel slot inside the strip, blanks included
    logic                blank_slot;
    logic                in_status;
    logic                in_box;
    logic                in_strip;

    // local offsets, wrap harmlessly outside their regions
    assign dx_digits = raster.x - overlay_pkg::coord_t'(overlay_pkg::digits_x);
    assign dy_digits = raster.y - overlay_pkg::coord_t'(overlay_pkg::digits_y);

    assign in_status = (raster.x >= overlay_pkg::status_x) &&
                       (raster.x <  overlay_pkg::status_x + overlay_pkg::glyph_size) &&
                       (raster.y >= overlay_pkg::status_y) &&
                       (raster.y <  overlay_pkg::status_y + overlay_pkg::glyph_size);

    assign in_box = (raster.x >= overlay_pkg::box_x) &&
                    (raster.x <  overlay_pkg::box_x + overlay_pkg::box_w) &&
                    (raster.y >= overlay_pkg::box_y) &&
                    (raster.y <  overlay_pkg::box_y + overlay_pkg::box_h);

    assign in_strip = (raster.x >= overlay_pkg::digits_x) &&
                      (raster.x <  overlay_pkg::digits_x + overlay_pkg::digits_w) &&
                      (raster.y >= overlay_pkg::digits_y) &&
                      (raster.y <  overlay_pkg::digits_y + overlay_pkg::digits_h);

    assign slot       = dx_digits[6:3];
    assign blank_slot = ((slot + 4'd1) % 4'd5) == 4'd0;   // every fifth slot separates groups

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pmap <= '0;
        end else begin
            pmap.display_en <= raster.display_en;
            pmap.in_status  <= in_status;
            pmap.in_box     <= in_box;
            pmap.in_digit   <= in_strip && !blank_slot;
            // status origin sits on the same 8-pixel grid as the digit strip
            pmap.glyph_row  <= dy_digits[2:0];
            pmap.glyph_col  <= dx_digits[2:0];
            pmap.digit_idx  <= slot - slot / 4'd5;
        end
    end

    // composer indexes the value register with this
    a_digit_idx_range: assert property (@(posedge clk) disable iff (!rst_n)
        pmap.in_digit |-> (pmap.digit_idx < overlay_pkg::value_w));

endmodule

// ==== rtl/glyph_rom.sv ====
`timescale 1ns/100ps

module glyph_rom #(
    parameter int glyph_id = 0
) (
    input  logic                          clk,
    input  overlay_pkg::pixel_map_t       pmap,
    output logic [overlay_pkg::rgb_w-1:0] rgb
);

    logic [7:0] row_bits;
    logic       ink;

    // one row of this rom's bitmap, bit 7 is the leftmost column
    assign row_bits = overlay_pkg::glyph_bitmap[glyph_id][pmap.glyph_row];
    assign ink      = row_bits[3'd7 - pmap.glyph_col];

    // registered read, same as a block RAM image
    always_ff @(posedge clk) begin
        if (ink)
            rgb <= overlay_pkg::ink_color;
        else
            rgb <= overlay_pkg::glyph_bg_color;
    end

endmodule

// ==== rtl/pixel_composer.sv ====
`timescale 1ns/100ps

module pixel_composer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  overlay_pkg::pixel_map_t       pmap,
    input  logic [overlay_pkg::rgb_w-1:0] glyph_rgb [overlay_pkg::num_glyphs],
    input  logic                          value_we,
    input  logic [overlay_pkg::value_w-1:0] value_data,
    input  overlay_pkg::issue_t           issue,
    input  logic                          switch_en,
    output logic [overlay_pkg::rgb_w-1:0] rgb
);

    logic [overlay_pkg::value_w-1:0] value_q;
    overlay_pkg::pixel_map_t         pmap_q;    // lines up with the rom outputs
    logic [3:0]                      bit_pos;
    logic                            digit_bit;
    logic [overlay_pkg::rgb_w-1:0]   status_rgb;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            value_q <= '0;
        else if (value_we)
            value_q <= value_data;   // written by the processor store path
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pmap_q <= '0;
        else
            pmap_q <= pmap;
    end

    // leftmost digit shows the msb
    assign bit_pos   = 4'(overlay_pkg::value_w - 1) - pmap_q.digit_idx;
    assign digit_bit = value_q[bit_pos];

    always_comb begin
        case (issue)
            overlay_pkg::issue_none:        status_rgb = glyph_rgb[overlay_pkg::glyph_normal];
            overlay_pkg::issue_uart:        status_rgb = glyph_rgb[overlay_pkg::glyph_uart];
            overlay_pkg::issue_pause:       status_rgb = glyph_rgb[overlay_pkg::glyph_pause];
            overlay_pkg::issue_fallthrough: status_rgb = glyph_rgb[overlay_pkg::glyph_fallthrough];
            overlay_pkg::issue_keypad:
                if (switch_en)
                    status_rgb = glyph_rgb[overlay_pkg::glyph_switch];   // user on the switches
                else
                    status_rgb = glyph_rgb[overlay_pkg::glyph_keypad];
            default:                        status_rgb = overlay_pkg::bg_color;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rgb <= '0;
        end else if (!pmap_q.display_en) begin
            rgb <= '0;   // blanking
        end else if (pmap_q.in_status) begin
            rgb <= status_rgb;
        end else if (pmap_q.in_digit) begin
            rgb <= digit_bit ? glyph_rgb[overlay_pkg::glyph_one]
                             : glyph_rgb[overlay_pkg::glyph_zero];
        end else if (pmap_q.in_box) begin
            rgb <= overlay_pkg::box_bg_color;
        end else begin
            rgb <= overlay_pkg::bg_color;
        end
    end

    // status icon and digit strip never overlap on screen
    a_regions_disjoint: assert property (@(posedge clk) disable iff (!rst_n)
        !(pmap.in_status && pmap.in_digit));

endmodule

// ==== rtl/vga_overlay_top.sv ====
`timescale 1ns/100ps

module vga_overlay_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            value_we,
    input  logic [overlay_pkg::value_w-1:0] value_data,
    input  overlay_pkg::issue_t             issue,
    input  logic                            switch_en,
    output logic [overlay_pkg::rgb_w-1:0]   rgb,
    output logic                            hsync,
    output logic                            vsync
);

    overlay_pkg::raster_t          raster;
    overlay_pkg::pixel_map_t       pmap;
    logic [overlay_pkg::rgb_w-1:0] glyph_rgb [overlay_pkg::num_glyphs];

    vga_timing u_vga_timing (
        .clk    (clk),
        .rst_n  (rst_n),
        .raster (raster),
        .hsync  (hsync),
        .vsync  (vsync)
    );

    coord_mapper u_coord_mapper (
        .clk    (clk),
        .rst_n  (rst_n),
        .raster (raster),
        .pmap   (pmap)
    );

    // one rom per glyph, all read at the same local row and column
    for (genvar i = 0; i < overlay_pkg::num_glyphs; i++) begin : g_glyph
        glyph_rom #(
            .glyph_id (i)
        ) u_glyph_rom (
            .clk  (clk),
            .pmap (pmap),
            .rgb  (glyph_rgb[i])
        );
    end

    pixel_composer u_pixel_composer (
        .clk        (clk),
        .rst_n      (rst_n),
        .pmap       (pmap),
        .glyph_rgb  (glyph_rgb),
        .value_we   (value_we),
        .value_data (value_data),
        .issue      (issue),
        .switch_en  (switch_en),
        .rgb        (rgb)
    );

endmodule

// ==== tests/tb_vga_overlay.sv ====
`timescale 1ns/100ps

module tb_vga_overlay;

    localparam int reset_cycles   = 5;
    localparam int frame_cycles   = overlay_pkg::h_total * overlay_pkg::v_total;
    localparam int run_frames     = 9;
    localparam int stim_frames    = 8;
    localparam int stim_line      = 124;   // inside vertical blanking
    localparam int total_checks   = run_frames * frame_cycles + 3;
    localparam int timeout_cycles = total_checks + reset_cycles + 2000;

    logic                            clk;
    logic                            rst_n;
    logic                            value_we;
    logic [overlay_pkg::value_w-1:0] value_data;
    overlay_pkg::issue_t             issue;
    logic                            switch_en;
    logic [overlay_pkg::rgb_w-1:0]   rgb;
    logic                            hsync;
    logic                            vsync;

    // reference model state
    logic [overlay_pkg::value_w-1:0] model_value;
    logic [2:0]                      model_issue;
    logic                            model_switch;
    int                              mh;
    int                              mv;
    int                              frame;
    logic                            running;
    logic                            run_done;
    logic [31:0]                     lfsr_state;
    int                              cycle_cnt;
    int                              checks;
    int                              rgb_errors;
    int                              sync_errors;

    // expected values wait here until the DUT pipeline catches up
    logic [overlay_pkg::rgb_w-1:0]   pipe_rgb [3];
    logic                            pipe_hs [3];
    logic                            pipe_vs [3];
    int                              pipe_f [3];
    int                              pipe_x [3];
    int                              pipe_y [3];

    vga_overlay_top u_vga_overlay_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .value_we   (value_we),
        .value_data (value_data),
        .issue      (issue),
        .switch_en  (switch_en),
        .rgb        (rgb),
        .hsync      (hsync),
        .vsync      (vsync)
    );

    always #20 clk = ~clk;

    // galois form, taps for x^32 + x^30 + x^26 + x^25 + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [overlay_pkg::rgb_w-1:0] glyph_pixel(input int gid, input int row,
                                                                  input int col);
        logic [7:0] bits;
        bits = overlay_pkg::glyph_bitmap[gid][row];
        return bits[7 - col] ? overlay_pkg::ink_color : overlay_pkg::glyph_bg_color;
    endfunction

    function automatic logic [overlay_pkg::rgb_w-1:0] expected_rgb(input int x, input int y);
        int k;
        int gid;
        if (x >= overlay_pkg::h_active || y >= overlay_pkg::v_active)
            return '0;
        if (x >= overlay_pkg::status_x && x < overlay_pkg::status_x + overlay_pkg::glyph_size &&
            y >= overlay_pkg::status_y && y < overlay_pkg::status_y + overlay_pkg::glyph_size) begin
            case (model_issue)
                3'd0: gid = overlay_pkg::glyph_normal;
                3'd1: gid = overlay_pkg::glyph_uart;
                3'd2: gid = overlay_pkg::glyph_pause;
                3'd3: gid = overlay_pkg::glyph_fallthrough;
                3'd4: gid = model_switch ? overlay_pkg::glyph_switch : overlay_pkg::glyph_keypad;
                default: return overlay_pkg::bg_color;   // codes 5..7
            endcase
            return glyph_pixel(gid, y - overlay_pkg::status_y, x - overlay_pkg::status_x);
        end
        if (x >= overlay_pkg::digits_x && x < overlay_pkg::digits_x + overlay_pkg::digits_w &&
            y >= overlay_pkg::digits_y && y < overlay_pkg::digits_y + overlay_pkg::digits_h) begin
            k = (x - overlay_pkg::digits_x) / overlay_pkg::glyph_size;
            if ((k + 1) % 5 != 0) begin
                gid = model_value[overlay_pkg::value_w - 1 - (k - k / 5)] ?
                      overlay_pkg::glyph_one : overlay_pkg::glyph_zero;
                return glyph_pixel(gid, y - overlay_pkg::digits_y,
                                   (x - overlay_pkg::digits_x) % overlay_pkg::glyph_size);
            end
        end
        if (x >= overlay_pkg::box_x && x < overlay_pkg::box_x + overlay_pkg::box_w &&
            y >= overlay_pkg::box_y && y < overlay_pkg::box_y + overlay_pkg::box_h)
            return overlay_pkg::box_bg_color;
        return overlay_pkg::bg_color;
    endfunction

    function automatic string pixel_tag(input int f, input int x, input int y);
        if (f < 0)
            return "pipeline fill";
        return $sformatf("frame %0d x %0d y %0d", f, x, y);
    endfunction

    task automatic check_rgb(input string name, input logic [overlay_pkg::rgb_w-1:0] exp,
                             input logic [overlay_pkg::rgb_w-1:0] act);
        checks++;
        if (act !== exp) begin
            rgb_errors++;
            $display("mismatch %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_sync(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            sync_errors++;
            $display("mismatch %s: expected %b actual %b", name, exp, act);
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        value_we     = 1'b0;
        value_data   = '0;
        issue        = overlay_pkg::issue_none;
        switch_en    = 1'b0;
        model_value  = '0;
        model_issue  = 3'd0;
        model_switch = 1'b0;
        mh           = 0;
        mv           = 0;
        frame        = 0;
        running      = 1'b0;
        run_done     = 1'b0;
        lfsr_state   = 32'd90188;
        cycle_cnt    = 0;
        checks       = 0;
        rgb_errors   = 0;
        sync_errors  = 0;
        for (int i = 0; i < 3; i++) begin
            pipe_rgb[i] = '0;   // DUT still shows reset values here
            pipe_hs[i]  = 1'b1;
            pipe_vs[i]  = 1'b1;
            pipe_f[i]   = -1;
            pipe_x[i]   = 0;
            pipe_y[i]   = 0;
        end
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        wait (run_done);
        $display("checks %0d, errors: rgb %0d, sync %0d", checks, rgb_errors, sync_errors);
        if (rgb_errors + sync_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // DUT counters start on the first edge that sees rst_n high
    always @(posedge clk) begin
        if (rst_n)
            running <= 1'b1;
    end

    always @(posedge clk) begin : drive_stimulus
        logic [31:0] r;
        logic        wr;
        logic        sw;
        logic [2:0]  code;
        if (value_we)
            value_we <= 1'b0;
        if (running && mv == stim_line && mh == 0 && frame < stim_frames) begin
            take_bits(1, r);
            wr = (frame == 0) ? 1'b1 : (frame == 5) ? 1'b0 : r[0];   // frame 5 keeps its digits
            take_bits(overlay_pkg::value_w, r);
            value_data <= r[overlay_pkg::value_w-1:0];
            if (wr)
                model_value = r[overlay_pkg::value_w-1:0];
            value_we <= wr;
            code = (frame < 4) ? 3'(frame + 1) : 3'(frame);   // codes 1..7 in turn, keypad twice
            issue       <= overlay_pkg::issue_t'(code);
            model_issue  = code;
            take_bits(1, r);
            sw = (frame == 3) ? 1'b0 : (frame == 4) ? 1'b1 : r[0];   // keypad with and without
            switch_en   <= sw;
            model_switch = sw;
            $display("frame %0d: write %b value %h issue %0d switch %b",
                     frame, wr, model_value, model_issue, model_switch);
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin : check_outputs
        string tag;
        if (!running) begin
            check_rgb("reset rgb", '0, rgb);
            check_sync("reset hsync", 1'b1, hsync);
            check_sync("reset vsync", 1'b1, vsync);
        end else if (!run_done) begin
            tag = pixel_tag(pipe_f[2], pipe_x[2], pipe_y[2]);
            check_rgb({"rgb ", tag}, pipe_rgb[2], rgb);
            check_sync({"hsync ", tag}, pipe_hs[2], hsync);
            check_sync({"vsync ", tag}, pipe_vs[2], vsync);
            for (int i = 2; i > 0; i--) begin
                pipe_rgb[i] = pipe_rgb[i-1];
                pipe_hs[i]  = pipe_hs[i-1];
                pipe_vs[i]  = pipe_vs[i-1];
                pipe_f[i]   = pipe_f[i-1];
                pipe_x[i]   = pipe_x[i-1];
                pipe_y[i]   = pipe_y[i-1];
            end
            pipe_rgb[0] = expected_rgb(mh, mv);
            pipe_hs[0]  = !(mh >= overlay_pkg::hsync_start && mh < overlay_pkg::hsync_end);
            pipe_vs[0]  = !(mv >= overlay_pkg::vsync_start && mv < overlay_pkg::vsync_end);
            pipe_f[0]   = frame;
            pipe_x[0]   = mh;
            pipe_y[0]   = mv;
            mh++;
            if (mh == overlay_pkg::h_total) begin
                mh = 0;
                mv++;
                if (mv == overlay_pkg::v_total) begin
                    mv = 0;
                    frame++;
                end
            end
            if (checks >= 3 * (total_checks + reset_cycles))
                run_done = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

endmodule

// ==== sources.f ====
rtl/overlay_pkg.sv
rtl/vga_timing.sv
rtl/coord_mapper.sv
rtl/glyph_rom.sv
rtl/pixel_composer.sv
rtl/vga_overlay_top.sv
tests/tb_vga_overlay.sv

// ==== Makefile ====
# Verilator build and run for the character-overlay video path

VERILATOR ?= verilator
TOP       ?= tb_vga_overlay
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation PASSED

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard rtl/*.sv tests/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
